// File: verilog/lb_pkg.sv
package lb_pkg;

  typedef logic [15:0] lb_word_t;

  typedef struct packed {
    lb_word_t addr;
    lb_word_t wdata;
    logic     rd;
    logic     wr;
  } lb_req_t;

  typedef struct packed {
    lb_word_t rdata;
    logic     strb;
  } lb_rsp_t;

  // local bus address map
  localparam lb_word_t ALC_RBUFF_A        = 16'h0010;
  localparam lb_word_t ALC_HARDLEVEL_A    = 16'h0100;
  localparam lb_word_t ACM_AQUADS_A       = 16'h0200;
  localparam lb_word_t FROM_LEVELS_A      = 16'h1000;
  localparam lb_word_t FROM_ACMDATA_A     = 16'h1100;
  localparam lb_word_t FLASH_DATA_A       = 16'h8000;
  localparam lb_word_t FLASH_CRASH_OFFSET = 16'h0400;

  // block lengths in words
  localparam int FROM_LEVELS_L       = 8;
  localparam int FROM_ACMDATA_L      = 8;
  localparam int MB_RING_BUFFER_SIZE = 16;
  localparam int RING_AW             = $clog2(MB_RING_BUFFER_SIZE);

  // wait limits in lb_clk cycles
  localparam int TIMEOUT_FLASH = 100000; // flash writes can be slow
  localparam int TIMEOUT_OTHER = 256;

  // ring entry layout, payload in 13:0
  localparam int LOG_ERR_B = 15;
  localparam int LOG_END_B = 14;

  // ring control words
  localparam lb_word_t RING_OPEN  = 16'hffff;
  localparam lb_word_t RING_CLOSE = 16'h0000;

endpackage

// File: verilog/crash_ring.sv
module crash_ring
  import lb_pkg::*;
(
  input  logic     lb_clk,
  input  logic     reset,
  input  logic     log_valid,
  input  lb_word_t log_word,
  input  lb_req_t  ring_req,
  output lb_rsp_t  ring_rsp
);

  lb_word_t           mem [MB_RING_BUFFER_SIZE];
  logic [RING_AW:0]   count;    // stored entries
  logic [RING_AW:0]   rd_ptr;
  logic               open;     // capture frozen while open

  always_ff @(posedge lb_clk) begin
    if (!open && log_valid && count < (RING_AW+1)'(MB_RING_BUFFER_SIZE))
      mem[count[RING_AW-1:0]] <= log_word;
  end

  always_ff @(posedge lb_clk) begin
    if (reset) begin
      count         <= '0;
      rd_ptr        <= '0;
      open          <= 1'b0;
      ring_rsp.strb <= 1'b0;
    end else begin
      ring_rsp.strb <= ring_req.rd | ring_req.wr;
      if (ring_req.wr) begin
        if (ring_req.wdata == RING_OPEN) begin
          open   <= 1'b1;
          rd_ptr <= '0;
        end else if (ring_req.wdata == RING_CLOSE) begin
          open   <= 1'b0;
          rd_ptr <= '0;
          count  <= '0;
        end
      end else if (ring_req.rd) begin
        if (rd_ptr < count) rd_ptr <= rd_ptr + 1'b1;
      end else if (!open && log_valid &&
                   count < (RING_AW+1)'(MB_RING_BUFFER_SIZE)) begin
        count <= count + 1'b1;
      end
    end
  end

  always_ff @(posedge lb_clk) begin
    if (rd_ptr < count) ring_rsp.rdata <= mem[rd_ptr[RING_AW-1:0]];
    else ring_rsp.rdata <= lb_word_t'(1) << LOG_END_B; // ran out of entries
  end

endmodule

// File: verilog/param_regs.sv
module param_regs
  import lb_pkg::*;
(
  input  logic       lb_clk,
  input  logic       reset,
  input  lb_req_t    regs_req,
  output lb_rsp_t    regs_rsp,
  input  logic [3:0] mon_addr,
  input  logic       mon_sel,
  output lb_word_t   mon_data
);

  lb_word_t levels [FROM_LEVELS_L];
  lb_word_t quads  [FROM_ACMDATA_L];

  logic       quad_bank;
  logic [2:0] widx;

  assign quad_bank = regs_req.addr[9]; // 0x02xx quads, 0x01xx levels
  assign widx      = regs_req.addr[2:0];

  always_ff @(posedge lb_clk) begin
    if (regs_req.wr) begin
      if (quad_bank) quads[widx] <= regs_req.wdata;
      else levels[widx] <= regs_req.wdata;
    end
    regs_rsp.rdata <= quad_bank ? quads[widx] : levels[widx];
  end

  always_ff @(posedge lb_clk) begin
    if (reset) regs_rsp.strb <= 1'b0;
    else regs_rsp.strb <= regs_req.rd | regs_req.wr;
  end

  // debug readback, words past the bank read as zero
  always_comb begin
    if (mon_addr[3]) mon_data = '0;
    else if (mon_sel) mon_data = quads[mon_addr[2:0]];
    else mon_data = levels[mon_addr[2:0]];
  end

endmodule

// File: verilog/lb_decode.sv
module lb_decode
  import lb_pkg::*;
(
  input  lb_req_t lb_req,
  output lb_rsp_t lb_rsp,
  output lb_req_t ring_req,
  input  lb_rsp_t ring_rsp,
  output lb_req_t regs_req,
  input  lb_rsp_t regs_rsp,
  output lb_req_t rom_req,
  input  lb_rsp_t rom_rsp,
  output lb_req_t flash_req,
  input  lb_rsp_t flash_rsp
);

  logic ring_sel;
  logic regs_sel;
  logic rom_sel;
  logic flash_sel;

  always_comb begin
    ring_sel  = (lb_req.addr == ALC_RBUFF_A);
    regs_sel  = (lb_req.addr >= ALC_HARDLEVEL_A &&
                 lb_req.addr <  ALC_HARDLEVEL_A + lb_word_t'(FROM_LEVELS_L)) ||
                (lb_req.addr >= ACM_AQUADS_A &&
                 lb_req.addr <  ACM_AQUADS_A + lb_word_t'(FROM_ACMDATA_L));
    rom_sel   = (lb_req.addr >= FROM_LEVELS_A &&
                 lb_req.addr <  FROM_LEVELS_A + lb_word_t'(FROM_LEVELS_L)) ||
                (lb_req.addr >= FROM_ACMDATA_A &&
                 lb_req.addr <  FROM_ACMDATA_A + lb_word_t'(FROM_ACMDATA_L));
    flash_sel = (lb_req.addr >= FLASH_DATA_A);
  end

  // addr and wdata go everywhere, strobes only to the selected target
  always_comb begin
    ring_req     = lb_req;
    ring_req.rd  = lb_req.rd & ring_sel;
    ring_req.wr  = lb_req.wr & ring_sel;
    regs_req     = lb_req;
    regs_req.rd  = lb_req.rd & regs_sel;
    regs_req.wr  = lb_req.wr & regs_sel;
    rom_req      = lb_req;
    rom_req.rd   = lb_req.rd & rom_sel;
    rom_req.wr   = lb_req.wr & rom_sel;
    flash_req    = lb_req;
    flash_req.rd = lb_req.rd & flash_sel;
    flash_req.wr = lb_req.wr & flash_sel;
  end

  // addr is held until strb, so the same decode picks the response
  always_comb begin
    if (ring_sel)       lb_rsp = ring_rsp;
    else if (regs_sel)  lb_rsp = regs_rsp;
    else if (rom_sel)   lb_rsp = rom_rsp;
    else if (flash_sel) lb_rsp = flash_rsp;
    else                lb_rsp = '0; // unmapped, master times out
  end

endmodule

// File: verilog/dma_engine.sv
module dma_engine
  import lb_pkg::*;
(
  input  logic       lb_clk,
  input  logic       reset,
  input  logic       dma_crash,
  output lb_req_t    lb_req,
  input  lb_rsp_t    lb_rsp,
  output logic       lb_timeout,
  output logic [7:0] timeouts,
  output logic       dma_done
);

  typedef enum logic [1:0] {ST_START, ST_WAIT_WR, ST_WAIT_RD, ST_DONE} state_t;
  typedef enum logic [1:0] {MODE_FLASH, MODE_LEVELS, MODE_CONFIG, MODE_DONE} mode_t;

  state_t      state;
  mode_t       mode;
  logic [1:0]  progress;
  lb_word_t    index;
  lb_word_t    rd_buff;    // last word read, reused after a read timeout
  logic [16:0] wait_cnt;

  logic     ring_end;
  logic     ring_err;
  logic     ring_full;
  lb_word_t crash_addr;

  assign ring_end   = rd_buff[LOG_END_B];
  assign ring_err   = rd_buff[LOG_ERR_B];
  assign ring_full  = (index == lb_word_t'(MB_RING_BUFFER_SIZE - 1));
  assign crash_addr = FLASH_DATA_A + FLASH_CRASH_OFFSET + index;

  always_ff @(posedge lb_clk) begin
    if (reset) begin
      lb_req     <= '0;
      lb_timeout <= 1'b0;
      timeouts   <= 8'd0;
      dma_done   <= 1'b0;
      state      <= ST_START;
      progress   <= 2'd0;
      index      <= '0;
      wait_cnt   <= '0;
      mode       <= dma_crash ? MODE_FLASH : MODE_LEVELS;
    end else begin
      case (state)
        ST_START: begin
          wait_cnt   <= '0;
          lb_timeout <= 1'b0;
          case (mode)
            MODE_FLASH: begin
              case (progress)
                2'd0: begin // open ring, freezes capture
                  lb_req.addr  <= ALC_RBUFF_A;
                  lb_req.wdata <= RING_OPEN;
                  lb_req.wr    <= 1'b1;
                  index        <= '0;
                  progress     <= 2'd1;
                  state        <= ST_WAIT_WR;
                end
                2'd1: begin
                  lb_req.addr <= ALC_RBUFF_A;
                  lb_req.rd   <= 1'b1;
                  progress    <= 2'd2;
                  state       <= ST_WAIT_RD;
                end
                2'd2: begin
                  lb_req.addr <= crash_addr;
                  lb_req.wr   <= 1'b1;
                  state       <= ST_WAIT_WR;
                  if (ring_end || ring_err || ring_full) begin
                    // status word closes the dump
                    lb_req.wdata <= {12'hff0, 1'b0, ring_end, ring_err, ring_full};
                    progress     <= 2'd3;
                  end else begin
                    lb_req.wdata <= rd_buff;
                    index        <= index + 16'd1;
                    progress     <= 2'd1;
                  end
                end
                default: begin // close ring and resume capture
                  lb_req.addr  <= ALC_RBUFF_A;
                  lb_req.wdata <= RING_CLOSE;
                  lb_req.wr    <= 1'b1;
                  index        <= '0;
                  progress     <= 2'd0;
                  mode         <= MODE_LEVELS;
                  state        <= ST_WAIT_WR;
                end
              endcase
            end
            MODE_LEVELS: begin
              if (progress == 2'd0) begin
                lb_req.addr <= FROM_LEVELS_A + index;
                lb_req.rd   <= 1'b1;
                progress    <= 2'd1;
                state       <= ST_WAIT_RD;
              end else begin
                lb_req.addr  <= ALC_HARDLEVEL_A + index;
                lb_req.wdata <= rd_buff << 4; // 12-bit comparator levels
                lb_req.wr    <= 1'b1;
                progress     <= 2'd0;
                state        <= ST_WAIT_WR;
                if (index == lb_word_t'(FROM_LEVELS_L - 1)) begin
                  index <= '0;
                  mode  <= MODE_CONFIG;
                end else begin
                  index <= index + 16'd1;
                end
              end
            end
            MODE_CONFIG: begin
              if (progress == 2'd0) begin
                lb_req.addr <= FROM_ACMDATA_A + index;
                lb_req.rd   <= 1'b1;
                progress    <= 2'd1;
                state       <= ST_WAIT_RD;
              end else begin
                lb_req.addr  <= ACM_AQUADS_A + index;
                lb_req.wdata <= rd_buff;
                lb_req.wr    <= 1'b1;
                progress     <= 2'd0;
                state        <= ST_WAIT_WR;
                if (index == lb_word_t'(FROM_ACMDATA_L - 1)) begin
                  index <= '0;
                  mode  <= MODE_DONE;
                end else begin
                  index <= index + 16'd1;
                end
              end
            end
            default: state <= ST_DONE;
          endcase
        end
        ST_WAIT_WR: begin
          lb_req.wr <= 1'b0;
          if (lb_rsp.strb) begin
            state <= ST_START;
          end else if (wait_cnt >= 17'(TIMEOUT_FLASH)) begin
            lb_timeout <= 1'b1;
            if (timeouts != 8'hff) timeouts <= timeouts + 8'd1;
            state <= ST_START;
          end else begin
            wait_cnt <= wait_cnt + 17'd1;
          end
        end
        ST_WAIT_RD: begin
          lb_req.rd <= 1'b0;
          if (lb_rsp.strb) begin
            rd_buff <= lb_rsp.rdata;
            state   <= ST_START;
          end else if (wait_cnt >= 17'(TIMEOUT_OTHER)) begin
            lb_timeout <= 1'b1;
            if (timeouts != 8'hff) timeouts <= timeouts + 8'd1;
            state <= ST_START;
          end else begin
            wait_cnt <= wait_cnt + 17'd1;
          end
        end
        default: begin
          dma_done <= 1'b1; // held until next reset
          lb_req   <= '0;
        end
      endcase
    end
  end

endmodule

// File: verilog/dma_top.sv
module dma_top
  import lb_pkg::*;
(
  input  logic       lb_clk,
  input  logic       reset,
  input  logic       dma_crash,
  input  logic       log_valid,
  input  lb_word_t   log_word,
  output lb_req_t    rom_req,
  input  lb_rsp_t    rom_rsp,
  output lb_req_t    flash_req,
  input  lb_rsp_t    flash_rsp,
  input  logic       mon_sel,
  input  logic [3:0] mon_addr,
  output lb_word_t   mon_data,
  output logic       lb_timeout,
  output logic [7:0] timeouts,
  output logic       dma_done
);

  lb_req_t lb_req;
  lb_rsp_t lb_rsp;
  lb_req_t ring_req;
  lb_rsp_t ring_rsp;
  lb_req_t regs_req;
  lb_rsp_t regs_rsp;

  dma_engine u_engine (
    .lb_clk, .reset, .dma_crash,
    .lb_req, .lb_rsp,
    .lb_timeout, .timeouts, .dma_done
  );

  lb_decode u_decode (
    .lb_req, .lb_rsp,
    .ring_req, .ring_rsp,
    .regs_req, .regs_rsp,
    .rom_req, .rom_rsp,
    .flash_req, .flash_rsp
  );

  crash_ring u_ring (
    .lb_clk, .reset, .log_valid, .log_word,
    .ring_req, .ring_rsp
  );

  param_regs u_regs (
    .lb_clk, .reset, .regs_req, .regs_rsp,
    .mon_addr, .mon_sel, .mon_data
  );

endmodule

// File: testbench/tb_lb_models.sv
module rom_model
  import lb_pkg::*;
(
  input  logic               lb_clk,
  input  logic               reset,
  input  lb_req_t            req,
  output lb_rsp_t            rsp,
  input  lb_word_t           stall_addr,
  input  lb_word_t [7:0]     levels,
  input  lb_word_t [7:0]     quads
);
  timeunit 1ns;
  timeprecision 10ps;

  logic [1:0] delay;

  always @(posedge lb_clk) begin
    if (reset) begin
      delay <= '0;
      rsp   <= '0;
    end else begin
      rsp.strb <= 1'b0;
      if (req.rd && req.addr != stall_addr) begin
        delay <= 2'd1; // stalled address never answers
      end else if (delay != 2'd0) begin
        delay <= delay - 2'd1;
        if (delay == 2'd1) begin
          rsp.strb <= 1'b1;
          if (req.addr >= FROM_ACMDATA_A) rsp.rdata <= quads[req.addr[2:0]];
          else rsp.rdata <= levels[req.addr[2:0]];
        end
      end
    end
  end

endmodule

module flash_model
  import lb_pkg::*;
(
  input  logic     lb_clk,
  input  logic     reset,
  input  lb_req_t  req,
  output lb_rsp_t  rsp,
  output logic     rec_valid,  // one pulse per accepted write
  output lb_word_t rec_addr,
  output lb_word_t rec_data
);
  timeunit 1ns;
  timeprecision 10ps;

  logic [1:0] delay;

  always @(posedge lb_clk) begin
    if (reset) begin
      delay     <= '0;
      rsp       <= '0;
      rec_valid <= 1'b0;
    end else begin
      rsp.strb  <= 1'b0;
      rec_valid <= 1'b0;
      if (req.wr) begin
        delay <= 2'd2;
      end else if (delay != 2'd0) begin
        delay <= delay - 2'd1;
        if (delay == 2'd1) begin
          rsp.strb  <= 1'b1;
          rec_valid <= 1'b1;
          rec_addr  <= req.addr; // master holds addr and wdata until strb
          rec_data  <= req.wdata;
        end
      end
    end
  end

endmodule

// File: testbench/tb_dma.sv
module tb_dma
  import lb_pkg::*;
();
  timeunit 1ns;
  timeprecision 10ps;

  localparam int NCASES     = 4;
  localparam int CASE_WORDS = 4 + FROM_LEVELS_L + FROM_ACMDATA_L;

  logic       lb_clk;
  logic       reset;
  logic       dma_crash;
  logic       log_valid;
  lb_word_t   log_word;
  lb_req_t    rom_req;
  lb_rsp_t    rom_rsp;
  lb_req_t    flash_req;
  lb_rsp_t    flash_rsp;
  logic       mon_sel;
  logic [3:0] mon_addr;
  lb_word_t   mon_data;
  logic       lb_timeout;
  logic [7:0] timeouts;
  logic       dma_done;

  lb_word_t       stall_addr;
  lb_word_t [7:0] rom_levels;
  lb_word_t [7:0] rom_quads;
  logic           rec_valid;
  lb_word_t       rec_addr;
  lb_word_t       rec_data;
  logic [7:0]     pulse_count;

  logic [15:0] case_mem [NCASES*CASE_WORDS];
  lb_word_t    got_addr_q[$];
  lb_word_t    got_data_q[$];
  lb_word_t    exp_addr_q[$];
  lb_word_t    exp_data_q[$];
  int          value_errors;
  int          other_errors;
  int          cycle_limit;
  int          cycles;
  logic        loaded;

  dma_top DUT (.*);

  rom_model u_rom (
    .lb_clk, .reset, .req(rom_req), .rsp(rom_rsp),
    .stall_addr, .levels(rom_levels), .quads(rom_quads)
  );

  flash_model u_flash (
    .lb_clk, .reset, .req(flash_req), .rsp(flash_rsp),
    .rec_valid, .rec_addr, .rec_data
  );

  initial begin
    lb_clk = 1'b0;
    forever #4 lb_clk = ~lb_clk;
  end

  always @(posedge lb_clk) begin
    if (rec_valid) begin
      got_addr_q.push_back(rec_addr);
      got_data_q.push_back(rec_data);
    end
  end

  // lb_timeout pulses seen since reset
  always @(posedge lb_clk) begin
    if (reset) pulse_count <= '0;
    else if (lb_timeout) pulse_count <= pulse_count + 8'd1;
  end

  task automatic check_word(input string what, input lb_word_t got, input lb_word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_count(input string what, input logic [7:0] got,
                             input logic [7:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %0d expected %0d", $time, what, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_flash(input lb_word_t got_a, input lb_word_t got_d,
                             input lb_word_t exp_a, input lb_word_t exp_d);
    if (got_a !== exp_a || got_d !== exp_d) begin
      $display("** Error at %0t: flash write %h=%h expected %h=%h",
               $time, got_a, got_d, exp_a, exp_d);
      value_errors++;
    end
  endtask

  // dump expected from the stop rule, ring holds at most the one word
  task automatic expect_dump(input logic has_log, input lb_word_t first);
    lb_word_t w;
    lb_word_t base;
    base = FLASH_DATA_A + FLASH_CRASH_OFFSET;
    for (int i = 0; i < MB_RING_BUFFER_SIZE; i++) begin
      w = (has_log && i == 0) ? first : 16'h4000;
      exp_addr_q.push_back(base + lb_word_t'(i));
      if (w[14] || w[15] || i == MB_RING_BUFFER_SIZE - 1) begin
        exp_data_q.push_back({12'hff0, 1'b0, w[14], w[15], i == MB_RING_BUFFER_SIZE - 1});
        break;
      end
      exp_data_q.push_back(w);
    end
  endtask

  task automatic run_case(input int k);
    int         b;
    lb_word_t   last;
    lb_word_t   raw;
    logic [7:0] exp_to;
    lb_word_t   exp_lv [FROM_LEVELS_L];
    lb_word_t   exp_qd [FROM_ACMDATA_L];
    b = k * CASE_WORDS;
    @(posedge lb_clk);
    reset      <= 1'b1;
    dma_crash  <= case_mem[b][0];
    log_valid  <= 1'b0;
    stall_addr <= case_mem[b+3];
    for (int i = 0; i < 8; i++) begin
      rom_levels[i] <= case_mem[b+4+i];
      rom_quads[i]  <= case_mem[b+12+i];
    end
    got_addr_q.delete();
    got_data_q.delete();
    exp_addr_q.delete();
    exp_data_q.delete();
    repeat (10) @(posedge lb_clk);
    reset     <= 1'b0;
    log_valid <= case_mem[b+1][0]; // captured before the engine opens the ring
    log_word  <= case_mem[b+2];
    @(posedge lb_clk);
    log_valid <= 1'b0;
    do @(negedge lb_clk); while (!dma_done);

    if (case_mem[b][0]) expect_dump(case_mem[b+1][0], case_mem[b+2]);
    last = '0;
    for (int i = 0; i < FROM_LEVELS_L; i++) begin
      raw = (FROM_LEVELS_A + lb_word_t'(i) == case_mem[b+3]) ? last : case_mem[b+4+i];
      last = raw;
      exp_lv[i] = raw << 4;
    end
    for (int i = 0; i < FROM_ACMDATA_L; i++) begin
      raw = (FROM_ACMDATA_A + lb_word_t'(i) == case_mem[b+3]) ? last : case_mem[b+12+i];
      last = raw;
      exp_qd[i] = raw;
    end

    if (got_addr_q.size() != exp_addr_q.size()) begin
      $display("case %0d: flash saw %0d writes but %0d were expected",
               k, got_addr_q.size(), exp_addr_q.size());
      other_errors++;
    end else begin
      for (int i = 0; i < exp_addr_q.size(); i++)
        check_flash(got_addr_q[i], got_data_q[i], exp_addr_q[i], exp_data_q[i]);
    end
    exp_to = (case_mem[b+3] == 16'hffff) ? 8'd0 : 8'd1;
    check_count($sformatf("case %0d timeouts", k), timeouts, exp_to);
    check_count($sformatf("case %0d timeout pulses", k), pulse_count, exp_to);

    for (int i = 0; i < 8; i++) begin
      @(posedge lb_clk);
      mon_sel  <= 1'b0;
      mon_addr <= 4'(i);
      @(negedge lb_clk);
      check_word($sformatf("case %0d level %0d", k, i), mon_data, exp_lv[i]);
      @(posedge lb_clk);
      mon_sel <= 1'b1;
      @(negedge lb_clk);
      check_word($sformatf("case %0d quad %0d", k, i), mon_data, exp_qd[i]);
    end
  endtask

  initial begin : watchdog
    cycles = 0;
    wait (loaded);
    while (cycles <= cycle_limit) begin
      @(posedge lb_clk);
      cycles++;
    end
    $display("run stopped after %0d cycles without finishing all cases", cycles);
    $display("Test failed");
    $finish;
  end

  initial begin
    reset      = 1'b1;
    dma_crash  = 1'b0;
    log_valid  = 1'b0;
    log_word   = '0;
    mon_sel    = 1'b0;
    mon_addr   = '0;
    stall_addr = 16'hffff;
    rom_levels = '0;
    rom_quads  = '0;
    value_errors = 0;
    other_errors = 0;
    loaded       = 1'b0;
    $readmemh("testbench/dma_cases.txt", case_mem);
    cycle_limit = 0;
    for (int k = 0; k < NCASES; k++) begin
      cycle_limit += (FROM_LEVELS_L + FROM_ACMDATA_L + MB_RING_BUFFER_SIZE + 2) * 10;
      if (case_mem[k*CASE_WORDS+3] != 16'hffff) cycle_limit += TIMEOUT_OTHER;
    end
    loaded = 1'b1;
    for (int k = 0; k < NCASES; k++) run_case(k);
    $display("value errors %0d, other errors %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: files.f
verilog/lb_pkg.sv
verilog/crash_ring.sv
verilog/param_regs.sv
verilog/lb_decode.sv
verilog/dma_engine.sv
verilog/dma_top.sv
testbench/tb_lb_models.sv
testbench/tb_dma.sv

// File: run_sim.sh
#!/bin/bash
# build and run the DMA testbench, verdict taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_dma -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  ; cat sim.log \
  && grep -q "^Test passed$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: testbench/dma_cases.txt
// per case: crash flag, log_valid flag, log word, stall address (ffff none)
// then 8 boot store level words, then 8 boot store quad words
0001 0001 0123 ffff
abc1 0012 0fff 1234 8000 7ff7 0005 fedc
1111 2222 3333 4444 5555 6666 7777 8888
0001 0001 8abc ffff
0101 0202 0303 0404 0505 0606 0707 0808
a0a0 b0b0 c0c0 d0d0 e0e0 f0f0 0a0a 0b0b
0000 0000 0000 1103
0fed 0cba 0987 0654 0321 0abc 0def 0111
9001 9002 9003 9004 9005 9006 9007 9008
0001 0000 0000 1005
f00f 0ff0 1248 8421 3c3c c3c3 5a5a a5a5
0042 0043 0044 0045 0046 0047 0048 0049
